// ==== hdl/dist_cfg_pkg.sv ====
package dist_cfg_pkg;

  // issue port groups.
  localparam int MEM_PORTS  = 3;
  localparam int EXEC_PORTS = 6;
  localparam int GROUP_SIZE = 3;
  localparam int N_PORTS    = MEM_PORTS + EXEC_PORTS;

  // first port of each group.
  localparam int MEM_BASE   = 0;
  localparam int ALU_BASE   = MEM_BASE + MEM_PORTS;
  localparam int SHIFT_BASE = ALU_BASE + GROUP_SIZE;

  // rotation counts run 0 to GROUP_SIZE-1.
  localparam int ROT_W = 2;

endpackage

// ==== hdl/slot_code_pkg.sv ====
package slot_code_pkg;

  // slot numbers up to 14, code 15 is reserved.
  localparam int SLOT_W = 4;

  // empty issue port.
  localparam logic [SLOT_W-1:0] NO_SLOT = '1;

endpackage

// ==== hdl/class_rank.sv ====
`timescale 1ns/100ps

module class_rank
  import slot_code_pkg::*;
#(
  parameter int N_SLOT   = 10,
  parameter int MAX_PICK = 3
) (
  input  logic [N_SLOT-1:0]               mask,
  output logic [MAX_PICK-1:0][SLOT_W-1:0] pick,
  output logic [SLOT_W-1:0]               count
);

  // rank of each slot within its class.
  logic [N_SLOT-1:0][SLOT_W-1:0] rank;

  // running popcount over the lower slots.
  always_comb begin : rank_blk
    logic [SLOT_W-1:0] run;
    run = '0;
    for (int s = 0; s < N_SLOT; s++) begin
      rank[s] = run;
      run = run + SLOT_W'(mask[s]);
    end
    count = run;
  end

  // pick i is the set slot whose rank is i.
  always_comb begin
    for (int i = 0; i < MAX_PICK; i++) begin
      pick[i] = NO_SLOT;
      for (int s = 0; s < N_SLOT; s++) begin
        if (mask[s] && rank[s] == SLOT_W'(i)) begin
          pick[i] = SLOT_W'(s);
        end
      end
    end
  end

endmodule

// ==== hdl/port_packer.sv ====
`timescale 1ns/100ps

module port_packer
  import dist_cfg_pkg::*;
  import slot_code_pkg::*;
(
  input  logic [MEM_PORTS-1:0][SLOT_W-1:0]  store_pick,
  input  logic [MEM_PORTS-1:0][SLOT_W-1:0]  load_pick,
  input  logic [EXEC_PORTS-1:0][SLOT_W-1:0] alu_pick,
  input  logic [GROUP_SIZE-1:0][SLOT_W-1:0] shift_pick,
  input  logic [SLOT_W-1:0]                 store_count,
  input  logic [SLOT_W-1:0]                 load_count,
  input  logic [SLOT_W-1:0]                 shift_count,
  output logic [MEM_PORTS-1:0][SLOT_W-1:0]  mem_lane,
  output logic [EXEC_PORTS-1:0][SLOT_W-1:0] exec_lane,
  output logic [ROT_W-1:0]                  mem_issued,
  output logic [ROT_W-1:0]                  shift_issued,
  output logic                              has_shift
);

  logic [ROT_W-1:0] store_clip;
  logic [ROT_W-1:0] load_clip;
  logic [ROT_W-1:0] shift_clip;
  logic [ROT_W:0]   mem_sum;

  // saturate a class count at one group.
  function automatic logic [ROT_W-1:0] clip_group(input logic [SLOT_W-1:0] c);
    if (c >= SLOT_W'(GROUP_SIZE)) begin
      return ROT_W'(GROUP_SIZE);
    end
    return c[ROT_W-1:0];
  endfunction

  assign store_clip = clip_group(store_count);
  assign load_clip  = clip_group(load_count);
  assign shift_clip = clip_group(shift_count);

  // stores first, loads follow behind them.
  always_comb begin
    for (int k = 0; k < MEM_PORTS; k++) begin
      if (k < store_clip) begin
        mem_lane[k] = store_pick[k];
      end else begin
        mem_lane[k] = load_pick[k - store_clip];
      end
    end
  end

  assign mem_sum = store_clip + load_clip;

  // at most one group of memory ops per bundle.
  assign mem_issued = (mem_sum >= (ROT_W+1)'(MEM_PORTS)) ? ROT_W'(MEM_PORTS) :
                      mem_sum[ROT_W-1:0];

  assign has_shift = (shift_count != '0);

  // upper exec group carries shifts, or alu overflow when there are none.
  always_comb begin
    for (int k = 0; k < GROUP_SIZE; k++) begin
      exec_lane[k] = alu_pick[k];
      if (has_shift) begin
        exec_lane[GROUP_SIZE + k] = shift_pick[k];
      end else begin
        exec_lane[GROUP_SIZE + k] = alu_pick[GROUP_SIZE + k];
      end
    end
  end

  // alu overflow does not move the shift rotation.
  assign shift_issued = shift_clip;

endmodule

// ==== hdl/issue_rotator.sv ====
`timescale 1ns/100ps

module issue_rotator
  import dist_cfg_pkg::*;
  import slot_code_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              stall,
  input  logic                              bundle_valid,
  input  logic [MEM_PORTS-1:0][SLOT_W-1:0]  mem_lane,
  input  logic [EXEC_PORTS-1:0][SLOT_W-1:0] exec_lane,
  input  logic [ROT_W-1:0]                  mem_issued,
  input  logic [ROT_W-1:0]                  shift_issued,
  input  logic                              has_shift,
  output logic [SLOT_W-1:0]                 port0,
  output logic [SLOT_W-1:0]                 port1,
  output logic [SLOT_W-1:0]                 port2,
  output logic [SLOT_W-1:0]                 port3,
  output logic [SLOT_W-1:0]                 port4,
  output logic [SLOT_W-1:0]                 port5,
  output logic [SLOT_W-1:0]                 port6,
  output logic [SLOT_W-1:0]                 port7,
  output logic [SLOT_W-1:0]                 port8
);

  logic [ROT_W-1:0]               mem_rot;
  logic [ROT_W-1:0]               shift_rot;
  logic [N_PORTS-1:0][SLOT_W-1:0] port_d;
  logic [N_PORTS-1:0][SLOT_W-1:0] port_q;

  // sum of two counts, modulo the group size.
  function automatic logic [ROT_W-1:0] mod_add(input logic [ROT_W-1:0] a,
                                               input logic [ROT_W-1:0] b);
    logic [ROT_W:0] s;
    s = a + b;
    if (s >= (ROT_W+1)'(GROUP_SIZE)) begin
      s = s - (ROT_W+1)'(GROUP_SIZE);
    end
    return s[ROT_W-1:0];
  endfunction

  always_comb begin
    port_d = {N_PORTS{NO_SLOT}};
    for (int k = 0; k < GROUP_SIZE; k++) begin
      port_d[MEM_BASE + mod_add(ROT_W'(k), mem_rot)] = mem_lane[k];
      port_d[ALU_BASE + k] = exec_lane[k];
      // alu overflow goes out in order.
      if (has_shift) begin
        port_d[SHIFT_BASE + mod_add(ROT_W'(k), shift_rot)] = exec_lane[GROUP_SIZE + k];
      end else begin
        port_d[SHIFT_BASE + k] = exec_lane[GROUP_SIZE + k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_rot   <= '0;
      shift_rot <= '0;
      port_q    <= {N_PORTS{NO_SLOT}};
    end else if (!stall) begin
      if (bundle_valid) begin
        port_q    <= port_d;
        mem_rot   <= mod_add(mem_rot, mem_issued);
        shift_rot <= mod_add(shift_rot, shift_issued);
      end else begin
        port_q <= {N_PORTS{NO_SLOT}};
      end
    end
  end

  assign port0 = port_q[0];
  assign port1 = port_q[1];
  assign port2 = port_q[2];
  assign port3 = port_q[3];
  assign port4 = port_q[4];
  assign port5 = port_q[5];
  assign port6 = port_q[6];
  assign port7 = port_q[7];
  assign port8 = port_q[8];

endmodule

// ==== hdl/dist_top.sv ====
`timescale 1ns/100ps

module dist_top
  import dist_cfg_pkg::*;
  import slot_code_pkg::*;
#(
  parameter int N_SLOT = 10
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              stall,
  input  logic              bundle_valid,
  input  logic [N_SLOT-1:0] alu,
  input  logic [N_SLOT-1:0] shift,
  input  logic [N_SLOT-1:0] load,
  input  logic [N_SLOT-1:0] store,
  output logic [SLOT_W-1:0] port0,
  output logic [SLOT_W-1:0] port1,
  output logic [SLOT_W-1:0] port2,
  output logic [SLOT_W-1:0] port3,
  output logic [SLOT_W-1:0] port4,
  output logic [SLOT_W-1:0] port5,
  output logic [SLOT_W-1:0] port6,
  output logic [SLOT_W-1:0] port7,
  output logic [SLOT_W-1:0] port8
);

  logic [MEM_PORTS-1:0][SLOT_W-1:0]  store_pick;
  logic [MEM_PORTS-1:0][SLOT_W-1:0]  load_pick;
  logic [EXEC_PORTS-1:0][SLOT_W-1:0] alu_pick;
  logic [GROUP_SIZE-1:0][SLOT_W-1:0] shift_pick;
  logic [SLOT_W-1:0]                 store_count;
  logic [SLOT_W-1:0]                 load_count;
  logic [SLOT_W-1:0]                 shift_count;
  logic [MEM_PORTS-1:0][SLOT_W-1:0]  mem_lane;
  logic [EXEC_PORTS-1:0][SLOT_W-1:0] exec_lane;
  logic [ROT_W-1:0]                  mem_issued;
  logic [ROT_W-1:0]                  shift_issued;
  logic                              has_shift;

  class_rank #(.N_SLOT(N_SLOT), .MAX_PICK(MEM_PORTS)) u_store_rank (
    .mask  (store),
    .pick  (store_pick),
    .count (store_count)
  );

  class_rank #(.N_SLOT(N_SLOT), .MAX_PICK(MEM_PORTS)) u_load_rank (
    .mask  (load),
    .pick  (load_pick),
    .count (load_count)
  );

  // alu count is not needed, exec ports take the picks as they come.
  class_rank #(.N_SLOT(N_SLOT), .MAX_PICK(EXEC_PORTS)) u_alu_rank (
    .mask  (alu),
    .pick  (alu_pick),
    .count ()
  );

  class_rank #(.N_SLOT(N_SLOT), .MAX_PICK(GROUP_SIZE)) u_shift_rank (
    .mask  (shift),
    .pick  (shift_pick),
    .count (shift_count)
  );

  port_packer u_port_packer (
    .store_pick   (store_pick),
    .load_pick    (load_pick),
    .alu_pick     (alu_pick),
    .shift_pick   (shift_pick),
    .store_count  (store_count),
    .load_count   (load_count),
    .shift_count  (shift_count),
    .mem_lane     (mem_lane),
    .exec_lane    (exec_lane),
    .mem_issued   (mem_issued),
    .shift_issued (shift_issued),
    .has_shift    (has_shift)
  );

  issue_rotator u_issue_rotator (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .bundle_valid (bundle_valid),
    .mem_lane     (mem_lane),
    .exec_lane    (exec_lane),
    .mem_issued   (mem_issued),
    .shift_issued (shift_issued),
    .has_shift    (has_shift),
    .port0        (port0),
    .port1        (port1),
    .port2        (port2),
    .port3        (port3),
    .port4        (port4),
    .port5        (port5),
    .port6        (port6),
    .port7        (port7),
    .port8        (port8)
  );

endmodule

// ==== tb/dist_assert.sv ====
`timescale 1ns/100ps

module dist_assert
  import dist_cfg_pkg::*;
  import slot_code_pkg::*;
(
  input logic                           clk,
  input logic                           rst,
  input logic                           stall,
  input logic [ROT_W-1:0]               mem_rot,
  input logic [ROT_W-1:0]               shift_rot,
  input logic [N_PORTS-1:0][SLOT_W-1:0] port_q
);

  int assert_fails = 0;

  // rotation counts stay inside one group.
  rot_range: assert property (@(posedge clk) disable iff (rst)
    mem_rot != ROT_W'(GROUP_SIZE) && shift_rot != ROT_W'(GROUP_SIZE))
  else begin
    $error("rotation count reached the group size");
    assert_fails = assert_fails + 1;
  end

  // a stalled cycle freezes ports and rotations.
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    stall |=> $stable(port_q) && $stable(mem_rot) && $stable(shift_rot))
  else begin
    $error("ports or rotations moved after a stall cycle");
    assert_fails = assert_fails + 1;
  end

  reset_clear: assert property (@(posedge clk)
    rst |=> port_q == {N_PORTS{NO_SLOT}} && mem_rot == '0 && shift_rot == '0)
  else begin
    $error("ports or rotations not cleared after reset");
    assert_fails = assert_fails + 1;
  end

endmodule

bind issue_rotator dist_assert u_dist_assert (
  .clk       (clk),
  .rst       (rst),
  .stall     (stall),
  .mem_rot   (mem_rot),
  .shift_rot (shift_rot),
  .port_q    (port_q)
);

// ==== tb/dist_tb.sv ====
`timescale 1ns/100ps

module dist_tb
  import dist_cfg_pkg::*;
  import slot_code_pkg::*;
;

  localparam int N_SLOT       = 10;
  localparam int NUM_HAND     = 20;
  localparam int NUM_RAND     = 20;
  localparam int NUM_ENTRY    = NUM_HAND + NUM_RAND;
  localparam int RESET_CYCLES = 16;
  localparam int EDGE_TIMEOUT = 100;
  localparam int RAND_SEED    = 91223;

  logic              clk = 1'b0;
  logic              rst;
  logic              stall;
  logic              bundle_valid;
  logic [N_SLOT-1:0] alu;
  logic [N_SLOT-1:0] shift;
  logic [N_SLOT-1:0] load;
  logic [N_SLOT-1:0] store;
  logic [SLOT_W-1:0] port0;
  logic [SLOT_W-1:0] port1;
  logic [SLOT_W-1:0] port2;
  logic [SLOT_W-1:0] port3;
  logic [SLOT_W-1:0] port4;
  logic [SLOT_W-1:0] port5;
  logic [SLOT_W-1:0] port6;
  logic [SLOT_W-1:0] port7;
  logic [SLOT_W-1:0] port8;

  // stimulus table.
  logic [N_SLOT-1:0] t_alu   [NUM_ENTRY];
  logic [N_SLOT-1:0] t_shift [NUM_ENTRY];
  logic [N_SLOT-1:0] t_load  [NUM_ENTRY];
  logic [N_SLOT-1:0] t_store [NUM_ENTRY];
  logic              t_valid [NUM_ENTRY];
  logic              t_stall [NUM_ENTRY];

  // reference model state.
  logic [SLOT_W-1:0] exp_port [N_PORTS];
  int                m_mem_rot;
  int                m_shift_rot;
  int                edge_count = 0;

  dist_top #(.N_SLOT(N_SLOT)) u_dist_top (
    .clk          (clk),
    .rst          (rst),
    .stall        (stall),
    .bundle_valid (bundle_valid),
    .alu          (alu),
    .shift        (shift),
    .load         (load),
    .store        (store),
    .port0        (port0),
    .port1        (port1),
    .port2        (port2),
    .port3        (port3),
    .port4        (port4),
    .port5        (port5),
    .port6        (port6),
    .port7        (port7),
    .port8        (port8)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  task automatic stop_fail();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on first error");
  endtask

  // returns one ns after the next rising edge.
  task automatic next_cycle();
    int start;
    int guard;
    start = edge_count;
    guard = 0;
    while (edge_count == start) begin
      #1;
      guard = guard + 1;
      if (guard > EDGE_TIMEOUT) begin
        $display("timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT);
        stop_fail();
      end
    end
  endtask

  task automatic set_entry(input int idx, input logic [N_SLOT-1:0] a,
                           input logic [N_SLOT-1:0] sh, input logic [N_SLOT-1:0] ld,
                           input logic [N_SLOT-1:0] st, input logic v, input logic s);
    t_alu[idx]   = a;
    t_shift[idx] = sh;
    t_load[idx]  = ld;
    t_store[idx] = st;
    t_valid[idx] = v;
    t_stall[idx] = s;
  endtask

  task automatic fill_table();
    int r;
    // memory sharing and rotation.
    set_entry(0,  10'h000, 10'h000, 10'h00c, 10'h003, 1'b1, 1'b0);
    set_entry(1,  10'h000, 10'h000, 10'h001, 10'h000, 1'b1, 1'b0);
    set_entry(2,  10'h000, 10'h000, 10'h030, 10'h100, 1'b1, 1'b0);
    set_entry(3,  10'h000, 10'h000, 10'h3c0, 10'h000, 1'b1, 1'b0);
    set_entry(4,  10'h000, 10'h000, 10'h000, 10'h2a8, 1'b1, 1'b0);
    set_entry(5,  10'h000, 10'h000, 10'h002, 10'h001, 1'b1, 1'b0);
    // alu only.
    set_entry(6,  10'h007, 10'h000, 10'h000, 10'h000, 1'b1, 1'b0);
    set_entry(7,  10'h03f, 10'h000, 10'h000, 10'h000, 1'b1, 1'b0);
    set_entry(8,  10'h3ff, 10'h000, 10'h000, 10'h000, 1'b1, 1'b0);
    set_entry(9,  10'h011, 10'h000, 10'h000, 10'h000, 1'b1, 1'b0);
    // shifts take the upper exec group.
    set_entry(10, 10'h00f, 10'h030, 10'h000, 10'h000, 1'b1, 1'b0);
    set_entry(11, 10'h000, 10'h001, 10'h000, 10'h000, 1'b1, 1'b0);
    set_entry(12, 10'h0c0, 10'h300, 10'h00c, 10'h003, 1'b1, 1'b0);
    set_entry(13, 10'h00f, 10'h0f0, 10'h000, 10'h000, 1'b1, 1'b0);
    // stall and idle cycles.
    set_entry(14, 10'h3ff, 10'h000, 10'h000, 10'h000, 1'b1, 1'b1);
    set_entry(15, 10'h000, 10'h3ff, 10'h000, 10'h000, 1'b0, 1'b1);
    set_entry(16, 10'h0ff, 10'h000, 10'h300, 10'h000, 1'b0, 1'b0);
    set_entry(17, 10'h003, 10'h00c, 10'h030, 10'h0c0, 1'b1, 1'b0);
    set_entry(18, 10'h300, 10'h003, 10'h00c, 10'h030, 1'b1, 1'b0);
    set_entry(19, 10'h2aa, 10'h155, 10'h000, 10'h000, 1'b1, 1'b0);
    // each slot lands in at most one class.
    for (int i = NUM_HAND; i < NUM_ENTRY; i++) begin
      set_entry(i, '0, '0, '0, '0, 1'b1, 1'b0);
      for (int s = 0; s < N_SLOT; s++) begin
        r = $urandom % 5;
        case (r)
          1: t_alu[i][s] = 1'b1;
          2: t_shift[i][s] = 1'b1;
          3: t_load[i][s] = 1'b1;
          4: t_store[i][s] = 1'b1;
          default: ;
        endcase
      end
      t_valid[i] = ($urandom % 8) != 0;
      t_stall[i] = ($urandom % 6) == 0;
    end
  endtask

  function automatic int count_set(input logic [N_SLOT-1:0] m);
    int n;
    n = 0;
    for (int s = 0; s < N_SLOT; s++) begin
      n = n + int'(m[s]);
    end
    return n;
  endfunction

  // slot number of the n-th set bit, counting from slot 0.
  function automatic logic [SLOT_W-1:0] nth_set(input logic [N_SLOT-1:0] m, input int n);
    logic [SLOT_W-1:0] r;
    int                seen;
    r = NO_SLOT;
    seen = 0;
    for (int s = 0; s < N_SLOT; s++) begin
      if (m[s]) begin
        if (seen == n) begin
          r = SLOT_W'(s);
        end
        seen = seen + 1;
      end
    end
    return r;
  endfunction

  task automatic update_model(input int i);
    int                n_st;
    int                n_ld;
    int                n_sh;
    int                n_mem;
    logic [SLOT_W-1:0] lane;
    if (!t_stall[i] && !t_valid[i]) begin
      for (int p = 0; p < N_PORTS; p++) begin
        exp_port[p] = NO_SLOT;
      end
    end else if (!t_stall[i]) begin
      n_st = count_set(t_store[i]);
      n_ld = count_set(t_load[i]);
      n_sh = count_set(t_shift[i]);
      for (int k = 0; k < GROUP_SIZE; k++) begin
        if (k < n_st) begin
          lane = nth_set(t_store[i], k);
        end else begin
          lane = nth_set(t_load[i], k - n_st);
        end
        exp_port[MEM_BASE + (k + m_mem_rot) % GROUP_SIZE] = lane;
        exp_port[ALU_BASE + k] = nth_set(t_alu[i], k);
        if (n_sh == 0) begin
          exp_port[SHIFT_BASE + k] = nth_set(t_alu[i], GROUP_SIZE + k);
        end else begin
          exp_port[SHIFT_BASE + (k + m_shift_rot) % GROUP_SIZE] = nth_set(t_shift[i], k);
        end
      end
      n_mem = (n_st + n_ld > GROUP_SIZE) ? GROUP_SIZE : n_st + n_ld;
      m_mem_rot = (m_mem_rot + n_mem) % GROUP_SIZE;
      m_shift_rot = (m_shift_rot + ((n_sh > GROUP_SIZE) ? GROUP_SIZE : n_sh)) % GROUP_SIZE;
    end
  endtask

  task automatic check_ports(input string tag);
    logic [SLOT_W-1:0] got [N_PORTS];
    got[0] = port0;
    got[1] = port1;
    got[2] = port2;
    got[3] = port3;
    got[4] = port4;
    got[5] = port5;
    got[6] = port6;
    got[7] = port7;
    got[8] = port8;
    for (int p = 0; p < N_PORTS; p++) begin
      assert (got[p] === exp_port[p]) else begin
        $display("error: %s port%0d got 0x%h expected 0x%h", tag, p, got[p], exp_port[p]);
        stop_fail();
      end
    end
  endtask

  initial begin
    void'($urandom(RAND_SEED));
    rst = 1'b1;
    stall = 1'b0;
    bundle_valid = 1'b0;
    alu = '0;
    shift = '0;
    load = '0;
    store = '0;
    m_mem_rot = 0;
    m_shift_rot = 0;
    for (int p = 0; p < N_PORTS; p++) begin
      exp_port[p] = NO_SLOT;
    end
    fill_table();

    repeat (RESET_CYCLES) next_cycle();
    check_ports("after reset");
    rst = 1'b0;
    next_cycle();

    // one entry per cycle, checked on the following edge.
    for (int i = 0; i < NUM_ENTRY; i++) begin
      alu = t_alu[i];
      shift = t_shift[i];
      load = t_load[i];
      store = t_store[i];
      bundle_valid = t_valid[i];
      stall = t_stall[i];
      update_model(i);
      next_cycle();
      check_ports($sformatf("entry %0d", i));
    end
    bundle_valid = 1'b0;
    next_cycle();

    if (u_dist_top.u_issue_rotator.u_dist_assert.assert_fails == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("concurrent assertions failed %0d times",
               u_dist_top.u_issue_rotator.u_dist_assert.assert_fails);
      stop_fail();
    end
  end

endmodule

// ==== Bender.yml ====
package:
  name: issue_dist

sources:
  - files:
      - hdl/dist_cfg_pkg.sv
      - hdl/slot_code_pkg.sv
      - hdl/class_rank.sv
      - hdl/port_packer.sv
      - hdl/issue_rotator.sv
      - hdl/dist_top.sv

  - target: test
    files:
      - tb/dist_assert.sv
      - tb/dist_tb.sv

// ==== all.f ====
hdl/dist_cfg_pkg.sv
hdl/slot_code_pkg.sv
hdl/class_rank.sv
hdl/port_packer.sv
hdl/issue_rotator.sv
hdl/dist_top.sv
tb/dist_assert.sv
tb/dist_tb.sv
